// File: gcn_accel.f
hdl/gcn_pkg.sv
hdl/gcn_sequencer.sv
hdl/gcn_node_lane.sv
hdl/gcn_result_writer.sv
hdl/gcn_top.sv
verification/gcn_checker.sv
verification/gcn_tb.sv

// File: hdl/gcn_node_lane.sv
module gcn_node_lane (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          feat_valid,
    input  logic                          last_feat,
    input  logic                          clear_scores,
    input  gcn_pkg::adj_row_t             adj_row,
    input  gcn_pkg::feat_col_t            feat_col,
    input  gcn_pkg::weight_row_t          weight_row,
    output logic                          class_valid,
    output logic [gcn_pkg::CLASS_W-1:0]   class_idx
);
    import gcn_pkg::*;

    // six 5-bit values need three extra bits
    localparam int AGG_W  = FEAT_W + 3;
    localparam int PROD_W = AGG_W + FEAT_W;

    logic [AGG_W-1:0]                      agg_next;
    logic [AGG_W-1:0]                      agg;
    weight_row_t                           w_q;
    logic                                  s1_valid;
    logic                                  s1_last;
    logic                                  s2_last;
    logic [NUM_CLASSES-1:0][PROD_W-1:0]    prod;
    logic [NUM_CLASSES-1:0][SCORE_W-1:0]   score;
    logic [CLASS_W-1:0]                    best_idx;
    logic [SCORE_W-1:0]                    best_score;

    ////////////////////////////////////////////////////////////
    // stage 1, masked neighbour sum
    ////////////////////////////////////////////////////////////

    always_comb begin
        agg_next = '0;
        for (int n = 0; n < NUM_NODES; n++) begin
            if (adj_row[n]) begin
                agg_next = agg_next + AGG_W'(feat_col[n]);
            end
        end
    end

    // weights ride along with their column
    always_ff @(posedge clk) begin
        if (feat_valid) begin
            agg <= agg_next;
            w_q <= weight_row;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2, weighted accumulation
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < NUM_CLASSES; c++) begin
            prod[c] = PROD_W'(agg) * PROD_W'(w_q[c]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score <= '0;
        end else if (clear_scores) begin
            score <= '0;
        end else if (s1_valid) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                score[c] <= score[c] + SCORE_W'(prod[c]);
            end
        end
    end

    // strict compare keeps the lower class on a tie
    always_comb begin
        best_idx   = '0;
        best_score = score[0];
        for (int c = 1; c < NUM_CLASSES; c++) begin
            if (score[c] > best_score) begin
                best_idx   = CLASS_W'(c);
                best_score = score[c];
            end
        end
    end

    // last_feat follows the data down the pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            s1_last     <= 1'b0;
            s2_last     <= 1'b0;
            class_valid <= 1'b0;
            class_idx   <= '0;
        end else begin
            s1_valid    <= feat_valid;
            s1_last     <= last_feat;
            s2_last     <= s1_last;
            class_valid <= s2_last;
            if (s2_last) begin
                class_idx <= best_idx;
            end
        end
    end

endmodule

// File: hdl/gcn_pkg.sv
package gcn_pkg;

    // graph size is fixed by the data memory word format
    localparam int NUM_NODES   = 6;
    // node numbers run 1..6, zero marks an unused edge slot
    localparam int NODE_W      = 3;
    localparam int FEAT_W      = 5;
    localparam int NUM_CLASSES = 3;
    localparam int CLASS_W     = 2;
    // wide enough for 64 feature columns
    localparam int SCORE_W     = 24;

    // one data memory word
    localparam int WORD_W      = NUM_NODES * FEAT_W;
    localparam int EDGE_PAD_W  = WORD_W - 2 * NODE_W;

    // feature column, node n sits in slot n-1
    typedef logic [NUM_NODES-1:0][FEAT_W-1:0] feat_col_t;

    // edge record, padding on top
    typedef struct packed {
        logic [EDGE_PAD_W-1:0] pad;
        logic [NODE_W-1:0]     src;
        logic [NODE_W-1:0]     dst;
    } edge_t;

    // same word seen as an edge or as a feature column
    typedef union packed {
        feat_col_t feat;
        edge_t     link;
    } mem_word_t;

    // one weight per class
    typedef logic [NUM_CLASSES-1:0][FEAT_W-1:0] weight_row_t;

    // one neighbour bit per node
    typedef logic [NUM_NODES-1:0] adj_row_t;

endpackage

// File: hdl/gcn_result_writer.sv
module gcn_result_writer (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  start,
    input  logic                                                  class_valid,
    input  logic [gcn_pkg::NUM_NODES-1:0][gcn_pkg::CLASS_W-1:0]   class_idx,
    output logic                                                  out_we,
    output logic [gcn_pkg::NODE_W-1:0]                            out_addr,
    output logic [gcn_pkg::CLASS_W-1:0]                           out_class,
    output logic                                                  done
);
    import gcn_pkg::*;

    logic [NUM_NODES-1:0][CLASS_W-1:0] cls_q;
    logic [NODE_W-1:0]                 next_addr;
    logic                              last_write;

    assign next_addr  = out_addr + NODE_W'(1);
    assign last_write = out_we && (out_addr == NODE_W'(NUM_NODES - 1));

    // snapshot of every lane class
    always_ff @(posedge clk) begin
        if (class_valid) begin
            cls_q <= class_idx;
        end
    end

    // address 0 carries node 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_we    <= 1'b0;
            out_addr  <= '0;
            out_class <= '0;
            done      <= 1'b0;
        end else begin
            if (class_valid) begin
                out_we    <= 1'b1;
                out_addr  <= '0;
                out_class <= class_idx[0];
            end else if (last_write) begin
                out_we <= 1'b0;
            end else if (out_we) begin
                out_addr  <= next_addr;
                out_class <= cls_q[next_addr];
            end
            // held until the next run starts
            if (last_write) begin
                done <= 1'b1;
            end else if (start) begin
                done <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/gcn_sequencer.sv
module gcn_sequencer #(
    parameter int NUM_EDGES = 6,
    parameter int NUM_FEATS = 16
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         start,
    input  logic                                         busy_clear,
    input  gcn_pkg::mem_word_t                           data_rdata,
    input  gcn_pkg::weight_row_t                         weight_rdata,
    output logic                                         mem_rd,
    output logic [6:0]                                   data_addr,
    output logic [5:0]                                   weight_addr,
    output logic                                         feat_valid,
    output logic                                         last_feat,
    output logic                                         clear_scores,
    output gcn_pkg::feat_col_t                           feat_col,
    output gcn_pkg::weight_row_t                         weight_row,
    output gcn_pkg::adj_row_t [gcn_pkg::NUM_NODES-1:0]   adj_rows
);
    import gcn_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_EDGE,
        S_FEAT,
        S_DRAIN
    } state_t;

    state_t            state;
    logic              accept;
    logic              edge_last;
    logic              feat_last;
    // which phase issued the read now returning
    logic              rd_edge_q;
    logic              rd_feat_q;
    logic              rd_last_q;
    edge_t             link;
    logic              link_ok;
    logic [NODE_W-1:0] src_idx;
    logic [NODE_W-1:0] dst_idx;

    ////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////

    // drain also counts as idle once the writer reports done
    assign accept    = start && ((state == S_IDLE) || (state == S_DRAIN && busy_clear));
    assign edge_last = (data_addr == 7'(NUM_EDGES - 1));
    assign feat_last = (weight_addr == 6'(NUM_FEATS - 1));
    assign mem_rd    = (state == S_EDGE) || (state == S_FEAT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            data_addr   <= '0;
            weight_addr <= '0;
        end else if (accept) begin
            state       <= S_EDGE;
            data_addr   <= '0;
            weight_addr <= '0;
        end else begin
            case (state)
                // edge words sit at the bottom of data memory
                S_EDGE: begin
                    data_addr <= data_addr + 7'd1;
                    if (edge_last) begin
                        state <= S_FEAT;
                    end
                end
                // feature column k goes with weight row k
                S_FEAT: begin
                    data_addr   <= data_addr + 7'd1;
                    weight_addr <= weight_addr + 6'd1;
                    if (feat_last) begin
                        state <= S_DRAIN;
                    end
                end
                // lanes and writer still busy
                S_DRAIN: begin
                    if (busy_clear) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // read data shows up one cycle after mem_rd
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_edge_q    <= 1'b0;
            rd_feat_q    <= 1'b0;
            rd_last_q    <= 1'b0;
            feat_valid   <= 1'b0;
            last_feat    <= 1'b0;
            clear_scores <= 1'b0;
        end else begin
            rd_edge_q    <= (state == S_EDGE);
            rd_feat_q    <= (state == S_FEAT);
            rd_last_q    <= (state == S_FEAT) && feat_last;
            feat_valid   <= rd_feat_q;
            last_feat    <= rd_last_q;
            clear_scores <= accept;
        end
    end

    // broadcast column and weights
    always_ff @(posedge clk) begin
        if (rd_feat_q) begin
            feat_col   <= data_rdata.feat;
            weight_row <= weight_rdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // adjacency matrix
    ////////////////////////////////////////////////////////////

    // node 0 means no edge, anything past the last node is dropped too
    assign link    = data_rdata.link;
    assign link_ok = rd_edge_q && (link.src != '0) && (link.dst != '0) &&
                     (link.src <= NUM_NODES) && (link.dst <= NUM_NODES);
    assign src_idx = link.src - NODE_W'(1);
    assign dst_idx = link.dst - NODE_W'(1);

    // symmetric set, repeats just set the same bits again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj_rows <= '0;
        end else if (accept) begin
            adj_rows <= '0;
        end else if (link_ok) begin
            adj_rows[src_idx][dst_idx] <= 1'b1;
            adj_rows[dst_idx][src_idx] <= 1'b1;
        end
    end

endmodule

// File: hdl/gcn_top.sv
module gcn_top #(
    parameter int NUM_EDGES = 6,
    parameter int NUM_FEATS = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    output logic                          mem_rd,
    output logic [6:0]                    data_addr,
    output logic [5:0]                    weight_addr,
    input  gcn_pkg::mem_word_t            data_rdata,
    input  gcn_pkg::weight_row_t          weight_rdata,
    output logic                          out_we,
    output logic [gcn_pkg::NODE_W-1:0]    out_addr,
    output logic [gcn_pkg::CLASS_W-1:0]   out_class,
    output logic                          done
);
    import gcn_pkg::*;

    // broadcast from the sequencer to every lane
    logic                              feat_valid;
    logic                              last_feat;
    logic                              clear_scores;
    feat_col_t                         feat_col;
    weight_row_t                       weight_row;
    adj_row_t [NUM_NODES-1:0]          adj_rows;

    // lane results, all lanes run in lockstep
    logic [NUM_NODES-1:0]              lane_valid;
    logic [NUM_NODES-1:0][CLASS_W-1:0] lane_class;

    gcn_sequencer #(
        .NUM_EDGES (NUM_EDGES),
        .NUM_FEATS (NUM_FEATS)
    ) u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .busy_clear   (done),
        .data_rdata   (data_rdata),
        .weight_rdata (weight_rdata),
        .mem_rd       (mem_rd),
        .data_addr    (data_addr),
        .weight_addr  (weight_addr),
        .feat_valid   (feat_valid),
        .last_feat    (last_feat),
        .clear_scores (clear_scores),
        .feat_col     (feat_col),
        .weight_row   (weight_row),
        .adj_rows     (adj_rows)
    );

    // one lane per graph node
    for (genvar n = 0; n < NUM_NODES; n++) begin : g_lane
        gcn_node_lane u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .feat_valid   (feat_valid),
            .last_feat    (last_feat),
            .clear_scores (clear_scores),
            .adj_row      (adj_rows[n]),
            .feat_col     (feat_col),
            .weight_row   (weight_row),
            .class_valid  (lane_valid[n]),
            .class_idx    (lane_class[n])
        );
    end

    // lane 0 valid stands for all lanes
    gcn_result_writer u_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .class_valid (lane_valid[0]),
        .class_idx   (lane_class),
        .out_we      (out_we),
        .out_addr    (out_addr),
        .out_class   (out_class),
        .done        (done)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the GCN testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module gcn_tb -f gcn_accel.f -o gcn_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/gcn_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its fail line on any error or timeout
if grep -q "Errors found" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation passed"
exit 0

// File: verification/gcn_checker.sv
module gcn_checker (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  start,
    input  logic                                                  mem_rd,
    input  logic                                                  out_we,
    input  logic [gcn_pkg::NODE_W-1:0]                            out_addr,
    input  logic [gcn_pkg::CLASS_W-1:0]                           out_class,
    input  logic                                                  done,
    input  logic [gcn_pkg::NUM_NODES-1:0][gcn_pkg::CLASS_W-1:0]   exp_class,
    input  logic                                                  report,
    output int                                                    check_count,
    output int                                                    err_count
);
    import gcn_pkg::*;

    logic seen_start;
    logic start_q;
    logic done_q;
    int   wr_count;

    initial begin
        check_count = 0;
        err_count   = 0;
        seen_start  = 1'b0;
        start_q     = 1'b0;
        done_q      = 1'b0;
        wr_count    = 0;
    end

    ////////////////////////////////////////////////////////////
    // sampled mid cycle, away from the rising edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            // quiet outputs between reset and the first start
            if (!seen_start) begin
                check_count++;
                if (mem_rd || out_we || done) begin
                    err_count++;
                    $display("ERR %0t: active before first start, mem_rd %0b out_we %0b done %0b",
                             $time, mem_rd, out_we, done);
                end
            end
            // a new run, the last one must have written every node
            if (start) begin
                if (seen_start && wr_count != NUM_NODES) begin
                    err_count++;
                    $display("ERR %0t: previous run wrote %0d nodes", $time, wr_count);
                end
                seen_start = 1'b1;
                wr_count   = 0;
            end
            // writes come in address order, one per node
            if (out_we) begin
                check_count++;
                if (wr_count >= NUM_NODES) begin
                    err_count++;
                    $display("ERR %0t: extra write at out_addr %0d", $time, out_addr);
                end else if (out_addr != NODE_W'(wr_count)) begin
                    err_count++;
                    $display("ERR %0t: out_addr %0d, expected %0d", $time, out_addr, wr_count);
                end else if (out_class != exp_class[wr_count]) begin
                    err_count++;
                    $display("ERR %0t: node %0d class %0d, expected %0d",
                             $time, wr_count + 1, out_class, exp_class[wr_count]);
                end
                wr_count++;
            end
            // done rises only after the sixth write
            if (done && !done_q) begin
                check_count++;
                if (wr_count != NUM_NODES) begin
                    err_count++;
                    $display("ERR %0t: done after %0d writes", $time, wr_count);
                end
            end
            // done may only fall after a start
            if (done_q && !done && !start_q) begin
                err_count++;
                $display("ERR %0t: done dropped without a start", $time);
            end
            start_q = start;
            done_q  = done;
        end
    end

    always @(posedge report) begin
        $display("checks %0d, errors %0d", check_count, err_count);
    end

endmodule

// File: verification/gcn_tb.sv
module gcn_tb;
    import gcn_pkg::*;

    localparam int          NUM_EDGES      = 6;
    localparam int          NUM_FEATS      = 16;
    localparam int          NUM_RUNS       = 8;
    localparam int          RESET_CYCLES   = 5;
    localparam logic [31:0] SEED           = 32'd42778;
    // generous bound per run plus reset
    localparam int          TIMEOUT_CYCLES = NUM_RUNS * (NUM_EDGES + NUM_FEATS + 20)
                                             + RESET_CYCLES;

    logic                              clk;
    logic                              rst_n;
    logic                              start;
    logic                              mem_rd;
    logic [6:0]                        data_addr;
    logic [5:0]                        weight_addr;
    mem_word_t                         data_rdata;
    weight_row_t                       weight_rdata;
    logic                              out_we;
    logic [NODE_W-1:0]                 out_addr;
    logic [CLASS_W-1:0]                out_class;
    logic                              done;
    logic [NUM_NODES-1:0][CLASS_W-1:0] exp_class;
    logic                              report;
    int                                check_count;
    int                                err_count;

    // memory models and their one cycle read pipe
    mem_word_t                         data_mem [0:127];
    weight_row_t                       weight_mem [0:63];
    logic                              rd_pending;
    logic [6:0]                        rd_data_addr;
    logic [5:0]                        rd_weight_addr;

    logic [31:0]                       rng_state;
    int                                cycle_count;
    int                                edge_src [NUM_EDGES];
    int                                edge_dst [NUM_EDGES];
    int                                feat [NUM_FEATS][NUM_NODES];
    int                                wgt [NUM_FEATS][NUM_CLASSES];

    gcn_top #(
        .NUM_EDGES (NUM_EDGES),
        .NUM_FEATS (NUM_FEATS)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .mem_rd       (mem_rd),
        .data_addr    (data_addr),
        .weight_addr  (weight_addr),
        .data_rdata   (data_rdata),
        .weight_rdata (weight_rdata),
        .out_we       (out_we),
        .out_addr     (out_addr),
        .out_class    (out_class),
        .done         (done)
    );

    gcn_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .mem_rd      (mem_rd),
        .out_we      (out_we),
        .out_addr    (out_addr),
        .out_class   (out_class),
        .done        (done),
        .exp_class   (exp_class),
        .report      (report),
        .check_count (check_count),
        .err_count   (err_count)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // memories, request seen after the edge, data one cycle later
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        #1;
        if (rd_pending) begin
            data_rdata   = data_mem[rd_data_addr];
            weight_rdata = weight_mem[rd_weight_addr];
        end
        rd_pending     = mem_rd;
        rd_data_addr   = data_addr;
        rd_weight_addr = weight_addr;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            report = 1'b1;
            #1;
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_below(input int limit, output int value);
        rng_state = xorshift32(rng_state);
        value     = int'(rng_state % 32'(limit));
    endtask

    // every word differs with its whole address
    task automatic fill_memories();
        for (int a = 0; a < 128; a++) begin
            data_mem[a] = 30'(32'(a) * 32'h9e37_79b1);
        end
        for (int a = 0; a < 64; a++) begin
            weight_mem[a] = 15'(32'(a) * 32'h85eb_ca6b);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus and reference model
    ////////////////////////////////////////////////////////////

    task automatic make_run(input int r);
        int s;
        int d;
        for (int e = 0; e < NUM_EDGES; e++) begin
            draw_below(7, s);
            draw_below(7, d);
            edge_src[e] = s;
            edge_dst[e] = d;
        end
        // run 1 holds a node 0 edge and a repeated edge
        if (r == 1) begin
            edge_src[0] = 0;
            draw_below(6, s);
            draw_below(6, d);
            edge_src[1]           = s + 1;
            edge_dst[1]           = d + 1;
            edge_src[NUM_EDGES-1] = edge_src[1];
            edge_dst[NUM_EDGES-1] = edge_dst[1];
        end
        for (int k = 0; k < NUM_FEATS; k++) begin
            for (int m = 0; m < NUM_NODES; m++) begin
                draw_below(32, s);
                feat[k][m] = s;
            end
        end
        // run 3 has all weights zero
        for (int k = 0; k < NUM_FEATS; k++) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                draw_below(32, s);
                wgt[k][c] = (r == 3) ? 0 : s;
            end
        end
    endtask

    // edges at the bottom, feature columns above them
    task automatic load_memories();
        mem_word_t   word;
        weight_row_t wrow;
        for (int e = 0; e < NUM_EDGES; e++) begin
            word          = '0;
            word.link.src = NODE_W'(edge_src[e]);
            word.link.dst = NODE_W'(edge_dst[e]);
            data_mem[e]   = word;
        end
        for (int k = 0; k < NUM_FEATS; k++) begin
            word = '0;
            for (int m = 0; m < NUM_NODES; m++) begin
                word.feat[m] = FEAT_W'(feat[k][m]);
            end
            data_mem[NUM_EDGES + k] = word;
            for (int c = 0; c < NUM_CLASSES; c++) begin
                wrow[c] = FEAT_W'(wgt[k][c]);
            end
            weight_mem[k] = wrow;
        end
    endtask

    task automatic compute_expected();
        logic adj [NUM_NODES][NUM_NODES];
        int   score [NUM_CLASSES];
        int   agg;
        int   best;
        for (int a = 0; a < NUM_NODES; a++) begin
            for (int b = 0; b < NUM_NODES; b++) begin
                adj[a][b] = 1'b0;
            end
        end
        // symmetric, node 0 edges skipped
        for (int e = 0; e < NUM_EDGES; e++) begin
            if (edge_src[e] != 0 && edge_dst[e] != 0) begin
                adj[edge_src[e]-1][edge_dst[e]-1] = 1'b1;
                adj[edge_dst[e]-1][edge_src[e]-1] = 1'b1;
            end
        end
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                score[c] = 0;
            end
            for (int k = 0; k < NUM_FEATS; k++) begin
                agg = 0;
                for (int m = 0; m < NUM_NODES; m++) begin
                    if (adj[n][m]) begin
                        agg += feat[k][m];
                    end
                end
                for (int c = 0; c < NUM_CLASSES; c++) begin
                    score[c] += agg * wgt[k][c];
                end
            end
            // lowest class wins a tie
            best = 0;
            for (int c = 1; c < NUM_CLASSES; c++) begin
                if (score[c] > score[best]) begin
                    best = c;
                end
            end
            exp_class[n] = CLASS_W'(best);
        end
    endtask

    // one start pulse, then wait for done and hold a little
    task automatic run_once();
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
        end
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        start          = 1'b0;
        report         = 1'b0;
        exp_class      = '0;
        data_rdata     = '0;
        weight_rdata   = '0;
        rd_pending     = 1'b0;
        rd_data_addr   = '0;
        rd_weight_addr = '0;
        rng_state      = SEED;
        cycle_count    = 0;
        fill_memories();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        // idle stretch before the first start
        repeat (3) @(posedge clk);
        #1;
        for (int r = 0; r < NUM_RUNS; r++) begin
            make_run(r);
            load_memories();
            compute_expected();
            run_once();
        end
        report = 1'b1;
        #1;
        if (err_count == 0 && check_count > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
